// File: Makefile
# Verilator simulation of the cache testbench

VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_TEXT ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/backing_memory.sv
`timescale 1ns/10ps

module backing_memory #(
  parameter int LINES = 64
) (
  input  logic                clk,
  input  logic                rst,
  input  cache_pkg::mem_req_t mem_req,
  input  logic                mem_req_valid,
  output logic                mem_req_ready,
  output cache_pkg::mem_rsp_t mem_rsp,
  output logic                mem_rsp_valid
);
  import cache_pkg::*;

  localparam int LINE_SEL_BITS = $clog2(LINES);

  line_t lines [LINES];

  // Transfer history, read by the testbench through the instance
  int unsigned       read_count = 0;
  int unsigned       write_count = 0;
  int unsigned       transfer_count = 0;
  int unsigned       last_read_seq = 0;
  int unsigned       last_write_seq = 0;
  logic [ADDR_W-1:0] last_read_addr = '0;
  logic [ADDR_W-1:0] last_write_addr = '0;
  line_t             last_write_data = '0;

  logic                     read_pending = 1'b0;
  int unsigned              read_delay = 0;
  logic [LINE_SEL_BITS-1:0] read_line = '0;

  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
    return (addr * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
  endfunction

  initial begin
    mem_req_ready = 1'b0;
    mem_rsp       = '0;
    mem_rsp_valid = 1'b0;
    for (int l = 0; l < LINES; l++) begin
      for (int w = 0; w < LINE_WORDS; w++) begin
        lines[l][w] = fill_word(ADDR_W'((l << OFFSET_BITS) + (w << 2)));
      end
    end
  end

  // Outputs change on the falling edge
  always @(negedge clk) begin
    mem_rsp_valid = 1'b0;
    if (rst) begin
      mem_req_ready = 1'b0;
      read_pending  = 1'b0;
    end else begin
      if (read_pending) begin
        if (read_delay == 0) begin
          mem_rsp.data  = lines[read_line];
          mem_rsp_valid = 1'b1;
          read_pending  = 1'b0;
        end else begin
          read_delay--;
        end
      end
      // Accepts three times in four
      mem_req_ready = ($urandom_range(3) != 0);
    end
  end

  always @(posedge clk) begin
    if (!rst && mem_req_valid && mem_req_ready) begin
      transfer_count++;
      if (mem_req.write) begin
        lines[mem_req.addr[OFFSET_BITS +: LINE_SEL_BITS]] = mem_req.data;
        write_count++;
        last_write_seq  = transfer_count;
        last_write_addr = mem_req.addr;
        last_write_data = mem_req.data;
      end else begin
        // Data returns 1 to 6 cycles after the transfer
        read_pending   = 1'b1;
        read_delay     = $urandom_range(5);
        read_line      = mem_req.addr[OFFSET_BITS +: LINE_SEL_BITS];
        read_count++;
        last_read_seq  = transfer_count;
        last_read_addr = mem_req.addr;
      end
    end
  end

endmodule

// File: bench/cache_tb.sv
`timescale 1ns/10ps

module cache_tb;
  import cache_pkg::*;

  localparam int INDEX_BITS     = 4;
  localparam int LINES          = 1 << INDEX_BITS;
  localparam int TAGS           = 4;
  localparam int TAG_W          = ADDR_W - INDEX_BITS - OFFSET_BITS;
  localparam int WINDOW_LINES   = TAGS * LINES;
  localparam int WORD_ADDR_BITS = $clog2(WINDOW_LINES * LINE_WORDS);
  localparam int RANDOM_OPS     = 2000;
  localparam int DIRECTED_OPS   = 40;
  // Cycles allowed for reset, every request and every flushed line
  localparam longint BUDGET = 20 + (RANDOM_OPS + DIRECTED_OPS) * 200 + LINES * 40;

  logic     clk;
  logic     rst;
  cpu_req_t req;
  logic     req_valid;
  logic     req_ready;
  cpu_rsp_t rsp;
  logic     rsp_valid;
  logic     rsp_ready;
  mem_req_t mem_req;
  logic     mem_req_valid;
  logic     mem_req_ready;
  mem_rsp_t mem_rsp;
  logic     mem_rsp_valid;
  logic     flush;
  logic     flush_busy;

  // Processor view of memory, and the line state the cache should hold
  logic [DATA_W-1:0] ref_mem [WINDOW_LINES * LINE_WORDS];
  logic [TAG_W-1:0]  shadow_tag [LINES];
  logic              shadow_valid [LINES];
  logic              shadow_dirty [LINES];

  cpu_req_t pending [$];
  cpu_rsp_t held_rsp;
  int       issued = 0;
  int       rsp_count = 0;
  int       cycle = 0;
  int       accept_cycle = 0;
  int       last_latency = 0;
  int       error_count = 0;
  logic     waiting_first = 1'b0;
  logic     hold_check = 1'b0;
  logic     backpressure = 1'b0;

  cache_top #(.INDEX_BITS(INDEX_BITS)) uut (.*);

  backing_memory #(.LINES(WINDOW_LINES)) mem_model (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [ADDR_W-1:0] line_addr(input int tag, input int index, input int word);
    return ADDR_W'(((tag * LINES + index) << OFFSET_BITS) + (word << 2));
  endfunction

  function automatic logic [DATA_W-1:0] initial_word(input logic [ADDR_W-1:0] addr);
    return (addr * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
  endfunction

  // Expected read data for a byte address
  function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
    return ref_mem[addr[2 +: WORD_ADDR_BITS]];
  endfunction

  function automatic void apply_write(input cpu_req_t r);
    for (int b = 0; b < STRB_W; b++) begin
      if (r.strb[b]) begin
        ref_mem[r.addr[2 +: WORD_ADDR_BITS]][b*8 +: 8] = r.wdata[b*8 +: 8];
      end
    end
  endfunction

  // A miss allocates the line clean and a write marks it dirty
  function automatic void track_line(input cpu_req_t r);
    logic [INDEX_BITS-1:0] idx;
    logic [TAG_W-1:0]      tag;
    idx = r.addr[OFFSET_BITS +: INDEX_BITS];
    tag = r.addr[ADDR_W-1 -: TAG_W];
    if (!shadow_valid[idx] || shadow_tag[idx] != tag) begin
      shadow_valid[idx] = 1'b1;
      shadow_tag[idx]   = tag;
      shadow_dirty[idx] = 1'b0;
    end
    if (r.write) begin
      shadow_dirty[idx] = 1'b1;
    end
  endfunction

  task automatic report_mismatch(input string name, input logic [DATA_W-1:0] got,
                                 input logic [DATA_W-1:0] exp);
    error_count++;
    $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    $display("Verification failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic report_error(input string what);
    error_count++;
    $display("%s at %0d ns", what, $time);
    $display("Verification failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
    assert (got == exp) else report_mismatch(name, got, exp);
  endtask

  // Drives one request and returns once its response has transferred
  task automatic request(input logic is_write, input logic [ADDR_W-1:0] addr,
                         input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb);
    @(negedge clk);
    req       = '{write: is_write, addr: addr, wdata: wdata, strb: strb};
    req_valid = 1'b1;
    while (!req_ready) begin
      @(negedge clk);
    end
    @(negedge clk);
    req_valid = 1'b0;
    issued++;
    while (rsp_count < issued) begin
      @(negedge clk);
    end
  endtask

  task automatic read_word(input logic [ADDR_W-1:0] addr);
    request(1'b0, addr, '0, '0);
  endtask

  always @(negedge clk) begin
    rsp_ready = backpressure ? ($urandom_range(1) == 1) : 1'b1;
  end

  // Response monitor and comparison
  always @(posedge clk) begin
    cpu_req_t done;
    if (!rst) begin
      cycle++;
      if (hold_check) begin
        assert (rsp_valid)
          else report_error("rsp_valid dropped while the response waited for rsp_ready");
        assert (rsp == held_rsp)
          else report_mismatch("rsp", rsp.rdata, held_rsp.rdata);
      end
      hold_check = rsp_valid && !rsp_ready;
      held_rsp   = rsp;
      if (waiting_first && rsp_valid) begin
        last_latency  = cycle - accept_cycle;
        waiting_first = 1'b0;
      end
      if (req_valid && req_ready) begin
        pending.push_back(req);
        accept_cycle  = cycle;
        waiting_first = 1'b1;
      end
      if (rsp_valid && rsp_ready) begin
        if (pending.size() == 0) begin
          report_error("Response arrived without an accepted request");
        end else begin
          done = pending.pop_front();
          if (done.write) begin
            apply_write(done);
          end else begin
            assert (rsp.rdata == expected_word(done.addr))
              else report_mismatch("rsp", rsp.rdata, expected_word(done.addr));
          end
          track_line(done);
          rsp_count++;
        end
      end
    end
  end

  initial begin
    #(BUDGET * 10);
    report_error("Timeout, the run did not finish within its cycle budget");
  end

  initial begin
    int                reads;
    int                writes;
    int                dirty;
    logic              rnd_write;
    logic [ADDR_W-1:0] rnd_addr;
    logic [STRB_W-1:0] rnd_strb;
    void'($urandom(98));
    rst       = 1'b1;
    req       = '0;
    req_valid = 1'b0;
    rsp_ready = 1'b0;
    flush     = 1'b0;
    for (int a = 0; a < WINDOW_LINES * LINE_WORDS; a++) begin
      ref_mem[a] = initial_word(ADDR_W'(a << 2));
    end
    for (int i = 0; i < LINES; i++) begin
      shadow_tag[i]   = '0;
      shadow_valid[i] = 1'b0;
      shadow_dirty[i] = 1'b0;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Idle outputs, a read miss, then a hit on the same line
    @(negedge clk);
    check_value("req_ready", 32'(req_ready), 1);
    check_value("rsp_valid", 32'(rsp_valid), 0);
    check_value("mem_req_valid", 32'(mem_req_valid), 0);
    check_value("flush_busy", 32'(flush_busy), 0);
    reads = mem_model.read_count;
    read_word(line_addr(1, 3, 2));
    check_value("mem read count", mem_model.read_count, reads + 1);
    check_value("mem_req.addr", mem_model.last_read_addr, line_addr(1, 3, 0));
    read_word(line_addr(1, 3, 1));
    check_value("mem read count", mem_model.read_count, reads + 1);
    // Valid is first sampled on the second edge after acceptance
    check_value("hit latency", last_latency, 2);

    // Partial writes to a hit line and to a missing line
    request(1'b1, line_addr(1, 3, 2), 32'h1122_3344, 4'b0101);
    request(1'b1, line_addr(2, 5, 0), 32'hA0B0_C0D0, 4'b1100);
    read_word(line_addr(1, 3, 2));
    read_word(line_addr(2, 5, 0));
    read_word(line_addr(2, 5, 3));

    // Dirty victim goes out before the new line is fetched
    request(1'b1, line_addr(0, 7, 1), 32'hDEAD_BEEF, 4'b0111);
    writes = mem_model.write_count;
    reads  = mem_model.read_count;
    read_word(line_addr(3, 7, 0));
    check_value("mem write count", mem_model.write_count, writes + 1);
    check_value("mem_req.addr", mem_model.last_write_addr, line_addr(0, 7, 0));
    for (int w = 0; w < LINE_WORDS; w++) begin
      check_value("mem_req.data", mem_model.last_write_data[w], expected_word(line_addr(0, 7, w)));
    end
    check_value("mem read count", mem_model.read_count, reads + 1);
    check_value("mem_req.addr", mem_model.last_read_addr, line_addr(3, 7, 0));
    assert (mem_model.last_write_seq < mem_model.last_read_seq)
      else report_error("Fill read was issued before the victim write-back");

    // Flush after a few more writes
    request(1'b1, line_addr(0, 0, 0), $urandom, 4'b1111);
    request(1'b1, line_addr(1, 1, 2), $urandom, 4'b0011);
    request(1'b1, line_addr(2, 2, 3), $urandom, 4'b1000);
    request(1'b1, line_addr(3, 9, 1), $urandom, 4'b1111);
    dirty = 0;
    for (int i = 0; i < LINES; i++) begin
      if (shadow_dirty[i]) begin
        dirty++;
      end
    end
    writes = mem_model.write_count;
    @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    check_value("flush_busy", 32'(flush_busy), 1);
    while (flush_busy) begin
      check_value("req_ready", 32'(req_ready), 0);
      @(negedge clk);
    end
    check_value("mem write count", mem_model.write_count, writes + dirty);
    for (int a = 0; a < WINDOW_LINES * LINE_WORDS; a++) begin
      check_value("memory word", mem_model.lines[a / LINE_WORDS][a % LINE_WORDS], ref_mem[a]);
    end
    for (int i = 0; i < LINES; i++) begin
      shadow_valid[i] = 1'b0;
      shadow_dirty[i] = 1'b0;
    end
    for (int i = 0; i < LINES; i++) begin
      reads = mem_model.read_count;
      read_word(line_addr(i % TAGS, i, 0));
      check_value("mem read count", mem_model.read_count, reads + 1);
    end

    // Random traffic with response back-pressure
    backpressure = 1'b1;
    for (int n = 0; n < RANDOM_OPS; n++) begin
      rnd_write = 1'($urandom_range(1));
      rnd_addr  = line_addr($urandom_range(TAGS - 1), $urandom_range(LINES - 1),
                            $urandom_range(LINE_WORDS - 1));
      rnd_strb  = STRB_W'($urandom_range(15));
      request(rnd_write, rnd_addr, $urandom, rnd_strb);
    end
    backpressure = 1'b0;

    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: project.f
source/cache_pkg.sv
source/cache_tag_store.sv
source/cache_data_store.sv
source/cache_controller.sv
source/cache_top.sv
bench/backing_memory.sv
bench/cache_tb.sv

// File: source/cache_controller.sv
`timescale 1ns/10ps

module cache_controller #(
  parameter int INDEX_BITS = 4,
  localparam int TAG_W = cache_pkg::ADDR_W - INDEX_BITS - cache_pkg::OFFSET_BITS
) (
  input  logic                            clk,
  input  logic                            rst,
  input  cache_pkg::cpu_req_t             req,
  input  logic                            req_valid,
  output logic                            req_ready,
  output cache_pkg::cpu_rsp_t             rsp,
  output logic                            rsp_valid,
  input  logic                            rsp_ready,
  output cache_pkg::mem_req_t             mem_req,
  output logic                            mem_req_valid,
  input  logic                            mem_req_ready,
  input  cache_pkg::mem_rsp_t             mem_rsp,
  input  logic                            mem_rsp_valid,
  input  logic                            flush,
  output logic                            flush_busy,
  output logic [INDEX_BITS-1:0]           tag_rindex,
  output logic [INDEX_BITS-1:0]           tag_windex,
  output logic                            tag_wen,
  output logic [TAG_W-1:0]                tag_wdata,
  output cache_pkg::line_meta_t           meta_wdata,
  output logic                            clear_all,
  input  logic [TAG_W-1:0]                tag_rdata,
  input  cache_pkg::line_meta_t           meta_rdata,
  output logic [INDEX_BITS-1:0]           line_rindex,
  output logic [INDEX_BITS-1:0]           line_windex,
  output logic [cache_pkg::LINE_WORDS-1:0] line_wen,
  output cache_pkg::line_t                line_wdata,
  input  cache_pkg::line_t                line_rdata
);
  import cache_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITEBACK,
    FILL_REQ,
    FILL_WAIT,
    RESPOND,
    FLUSH_READ,
    FLUSH_CHECK
  } state_t;

  function automatic logic [DATA_W-1:0] merge_word(input logic [DATA_W-1:0] old_word,
                                                   input logic [DATA_W-1:0] new_word,
                                                   input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] result;
    result = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        result[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return result;
  endfunction

  state_t                   state;
  state_t                   state_next;
  cpu_req_t                 req_q;
  logic [DATA_W-1:0]        rsp_word_q;
  logic [DATA_W-1:0]        rsp_word_d;
  logic                     flush_pending;
  logic [INDEX_BITS-1:0]    flush_idx;
  logic                     flush_step;

  logic                     accept;
  logic [INDEX_BITS-1:0]    req_index;
  logic [TAG_W-1:0]         req_tag;
  logic [WORD_SEL_BITS-1:0] req_word;
  logic                     hit;
  logic                     victim_dirty;
  logic [DATA_W-1:0]        lookup_word;
  logic [DATA_W-1:0]        fill_word;

  // Address fields of the registered request
  assign req_index = req_q.addr[OFFSET_BITS +: INDEX_BITS];
  assign req_tag   = req_q.addr[ADDR_W-1 -: TAG_W];
  assign req_word  = req_q.addr[OFFSET_BITS-1 -: WORD_SEL_BITS];

  assign req_ready = (state == IDLE) && !flush_pending;
  assign accept    = req_valid && req_ready;

  assign hit          = meta_rdata.valid && (tag_rdata == req_tag);
  assign victim_dirty = meta_rdata.valid && meta_rdata.dirty;
  assign lookup_word  = line_rdata[req_word];
  assign fill_word    = mem_rsp.data[req_word];

  // Both stores read the same line; the index is held steady while a miss is serviced
  always_comb begin
    if (state == IDLE) begin
      tag_rindex = req.addr[OFFSET_BITS +: INDEX_BITS];
    end else if (state == FLUSH_READ || state == FLUSH_CHECK) begin
      tag_rindex = flush_idx;
    end else begin
      tag_rindex = req_index;
    end
  end
  assign line_rindex = tag_rindex;

  assign rsp.rdata  = rsp_word_q;
  assign rsp_valid  = (state == RESPOND);
  assign flush_busy = flush_pending;

  always_comb begin
    state_next    = state;
    rsp_word_d    = rsp_word_q;
    flush_step    = 1'b0;
    clear_all     = 1'b0;
    tag_wen       = 1'b0;
    tag_windex    = req_index;
    tag_wdata     = req_tag;
    meta_wdata    = '0;
    line_wen      = '0;
    line_windex   = req_index;
    line_wdata    = mem_rsp.data;
    mem_req_valid = 1'b0;
    mem_req.write = 1'b0;
    mem_req.addr  = {req_tag, req_index, {OFFSET_BITS{1'b0}}};
    mem_req.data  = line_rdata;

    case (state)
      IDLE: begin
        if (flush_pending) begin
          state_next = FLUSH_READ;
        end else if (accept) begin
          state_next = LOOKUP;
        end
      end

      LOOKUP: begin
        if (hit) begin
          rsp_word_d = lookup_word;
          if (req_q.write) begin
            // Only the addressed word bank is written
            line_wen[req_word] = 1'b1;
            line_wdata         = {LINE_WORDS{merge_word(lookup_word, req_q.wdata, req_q.strb)}};
            tag_wen            = 1'b1;
            meta_wdata         = '{valid: 1'b1, dirty: 1'b1};
          end
          state_next = RESPOND;
        end else if (victim_dirty) begin
          state_next = WRITEBACK;
        end else begin
          state_next = FILL_REQ;
        end
      end

      WRITEBACK: begin
        // Victim tag and line are still on the store outputs
        mem_req_valid = 1'b1;
        mem_req.write = 1'b1;
        mem_req.addr  = {tag_rdata, req_index, {OFFSET_BITS{1'b0}}};
        if (mem_req_ready) begin
          state_next = FILL_REQ;
        end
      end

      FILL_REQ: begin
        mem_req_valid = 1'b1;
        if (mem_req_ready) begin
          state_next = FILL_WAIT;
        end
      end

      FILL_WAIT: begin
        if (mem_rsp_valid) begin
          line_wen   = '1;
          rsp_word_d = fill_word;
          if (req_q.write) begin
            line_wdata[req_word] = merge_word(fill_word, req_q.wdata, req_q.strb);
          end
          tag_wen    = 1'b1;
          meta_wdata = '{valid: 1'b1, dirty: req_q.write};
          state_next = RESPOND;
        end
      end

      RESPOND: begin
        if (rsp_ready) begin
          state_next = IDLE;
        end
      end

      FLUSH_READ: begin
        state_next = FLUSH_CHECK;
      end

      FLUSH_CHECK: begin
        if (victim_dirty) begin
          mem_req_valid = 1'b1;
          mem_req.write = 1'b1;
          mem_req.addr  = {tag_rdata, flush_idx, {OFFSET_BITS{1'b0}}};
          flush_step    = mem_req_ready;
        end else begin
          flush_step = 1'b1;
        end
        if (flush_step) begin
          if (flush_idx == '1) begin
            clear_all  = 1'b1;
            state_next = IDLE;
          end else begin
            state_next = FLUSH_READ;
          end
        end
      end

      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= IDLE;
      flush_pending <= 1'b0;
      flush_idx     <= '0;
    end else begin
      state <= state_next;
      if (clear_all) begin
        flush_pending <= 1'b0;
      end
      // A new pulse on the final cycle starts another flush
      if (flush) begin
        flush_pending <= 1'b1;
      end
      // Wraps back to zero after the last line
      if (flush_step) begin
        flush_idx <= flush_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req;
    end
    rsp_word_q <= rsp_word_d;
  end

endmodule

// File: source/cache_data_store.sv
`timescale 1ns/10ps

module cache_data_store #(
  parameter int INDEX_BITS = 4
) (
  input  logic                             clk,
  input  logic [INDEX_BITS-1:0]            rindex,
  input  logic [INDEX_BITS-1:0]            windex,
  input  logic [cache_pkg::LINE_WORDS-1:0] wen,
  input  cache_pkg::line_t                 wdata,
  output cache_pkg::line_t                 rdata
);
  import cache_pkg::*;

  localparam int LINES = 1 << INDEX_BITS;

  // One bank per word so a single-word write leaves the others untouched
  for (genvar w = 0; w < LINE_WORDS; w++) begin : g_bank
    logic [DATA_W-1:0] bank [LINES];
    logic [DATA_W-1:0] word_q;

    always_ff @(posedge clk) begin
      word_q <= bank[rindex];
      if (wen[w]) begin
        bank[windex] <= wdata[w];
      end
    end

    assign rdata[w] = word_q;
  end

endmodule

// File: source/cache_pkg.sv
package cache_pkg;

  // Processor word and address sizes
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // Line geometry: 4 words of 4 bytes
  localparam int LINE_WORDS    = 4;
  localparam int OFFSET_BITS   = 4;
  localparam int WORD_SEL_BITS = 2;

  typedef logic [LINE_WORDS-1:0][DATA_W-1:0] line_t;

  typedef struct packed {
    logic valid;
    logic dirty;
  } line_meta_t;

  // Processor request, write data and strobes ignored on reads
  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] strb;
  } cpu_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
  } cpu_rsp_t;

  // Line-wide memory request, address is line aligned
  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    line_t             data;
  } mem_req_t;

  typedef struct packed {
    line_t data;
  } mem_rsp_t;

endpackage

// File: source/cache_tag_store.sv
`timescale 1ns/10ps

module cache_tag_store #(
  parameter int INDEX_BITS = 4,
  localparam int TAG_W = cache_pkg::ADDR_W - INDEX_BITS - cache_pkg::OFFSET_BITS
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [INDEX_BITS-1:0] rindex,
  input  logic [INDEX_BITS-1:0] windex,
  input  logic                  wen,
  input  logic [TAG_W-1:0]      tag_wdata,
  input  cache_pkg::line_meta_t meta_wdata,
  input  logic                  clear_all,
  output logic [TAG_W-1:0]      tag_rdata,
  output cache_pkg::line_meta_t meta_rdata
);
  import cache_pkg::*;

  localparam int LINES = 1 << INDEX_BITS;

  logic [TAG_W-1:0] tags [LINES];
  line_meta_t       meta [LINES];

  // Tag array maps to RAM
  always_ff @(posedge clk) begin
    tag_rdata <= tags[rindex];
    if (wen) begin
      tags[windex] <= tag_wdata;
    end
  end

  // Flags live in flops so the whole cache can be invalidated in one cycle
  always_ff @(posedge clk) begin
    if (rst || clear_all) begin
      for (int i = 0; i < LINES; i++) begin
        meta[i] <= '0;
      end
    end else if (wen) begin
      meta[windex] <= meta_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      meta_rdata <= '0;
    end else begin
      meta_rdata <= meta[rindex];
    end
  end

endmodule

// File: source/cache_top.sv
`timescale 1ns/10ps

module cache_top #(
  parameter int INDEX_BITS = 4,
  localparam int TAG_W = cache_pkg::ADDR_W - INDEX_BITS - cache_pkg::OFFSET_BITS
) (
  input  logic               clk,
  input  logic               rst,
  input  cache_pkg::cpu_req_t req,
  input  logic               req_valid,
  output logic               req_ready,
  output cache_pkg::cpu_rsp_t rsp,
  output logic               rsp_valid,
  input  logic               rsp_ready,
  output cache_pkg::mem_req_t mem_req,
  output logic               mem_req_valid,
  input  logic               mem_req_ready,
  input  cache_pkg::mem_rsp_t mem_rsp,
  input  logic               mem_rsp_valid,
  input  logic               flush,
  output logic               flush_busy
);
  import cache_pkg::*;

  logic [INDEX_BITS-1:0] tag_rindex;
  logic [INDEX_BITS-1:0] tag_windex;
  logic                  tag_wen;
  logic [TAG_W-1:0]      tag_wdata;
  logic [TAG_W-1:0]      tag_rdata;
  line_meta_t            meta_wdata;
  line_meta_t            meta_rdata;
  logic                  clear_all;

  logic [INDEX_BITS-1:0] line_rindex;
  logic [INDEX_BITS-1:0] line_windex;
  logic [LINE_WORDS-1:0] line_wen;
  line_t                 line_wdata;
  line_t                 line_rdata;

  cache_controller #(.INDEX_BITS(INDEX_BITS)) u_controller (.*);

  cache_tag_store #(.INDEX_BITS(INDEX_BITS)) u_tag_store (
    .clk        (clk),
    .rst        (rst),
    .rindex     (tag_rindex),
    .windex     (tag_windex),
    .wen        (tag_wen),
    .tag_wdata  (tag_wdata),
    .meta_wdata (meta_wdata),
    .clear_all  (clear_all),
    .tag_rdata  (tag_rdata),
    .meta_rdata (meta_rdata)
  );

  cache_data_store #(.INDEX_BITS(INDEX_BITS)) u_data_store (
    .clk    (clk),
    .rindex (line_rindex),
    .windex (line_windex),
    .wen    (line_wen),
    .wdata  (line_wdata),
    .rdata  (line_rdata)
  );

endmodule
